// ==== design/soc_pkg.sv ====
package soc_pkg;

  ////////////////////
  // Bus widths
  ////////////////////
  localparam int DATA_WIDTH      = 32;
  localparam int ADDR_WIDTH      = 16;
  localparam int IO_WIDTH        = 10;
  localparam int DMEM_WORDS_LOG2 = 10;
  localparam int DMEM_WORDS      = 1 << DMEM_WORDS_LOG2;

  typedef logic [DATA_WIDTH-1:0]      data_t;
  typedef logic [ADDR_WIDTH-1:0]      addr_t;
  // Bit 3 is the high byte, lowest address
  typedef logic [3:0]                 strobe_t;
  typedef logic [1:0]                 gran_t;
  typedef logic [DMEM_WORDS_LOG2-1:0] dmem_idx_t;
  typedef logic [IO_WIDTH-1:0]        io_t;
  typedef logic [7:0]                 byte_t;
  typedef logic [15:0]                baud_div_t;

  // Access size, anything else is a word
  localparam gran_t GRAN_BYTE = 2'd1;
  localparam gran_t GRAN_HALF = 2'd2;

  ////////////////////
  // Address map
  ////////////////////
  localparam addr_t ADDR_DMEM_LIMIT = 16'h4000;
  localparam addr_t ADDR_LED        = 16'hC000;
  localparam addr_t ADDR_SW         = 16'hC001;
  localparam addr_t ADDR_UART_BUF   = 16'hC004;
  localparam addr_t ADDR_UART_STAT  = 16'hC005;
  localparam addr_t ADDR_UART_DBL   = 16'hC006;
  localparam addr_t ADDR_UART_DBH   = 16'hC007;

  ////////////////////
  // UART
  ////////////////////
  typedef enum logic [1:0] {SEL_BUF, SEL_STAT, SEL_DBL, SEL_DBH} uart_sel_t;
  // Short divisor keeps simulation frames small
  localparam baud_div_t BAUD_DIV_RESET = 16'd16;
  typedef enum logic [1:0] {IDLE, START, DATA, STOP} uart_state_t;

endpackage

// ==== design/periph_bus_if.sv ====
interface periph_bus_if;
  import soc_pkg::*;

  // Data memory side
  strobe_t   mem_we;
  dmem_idx_t mem_addr;
  data_t     mem_wdata;
  gran_t     mem_gran;
  data_t     mem_rdata;

  // UART register side
  logic      uart_cs;
  logic      uart_wr;
  uart_sel_t uart_sel;
  byte_t     uart_wdata;
  byte_t     uart_rdata;

  modport ctrl (
    output mem_we, mem_addr, mem_wdata, mem_gran,
    output uart_cs, uart_wr, uart_sel, uart_wdata,
    input  mem_rdata, uart_rdata
  );
  modport mem_tgt (input mem_we, mem_addr, mem_wdata, mem_gran, output mem_rdata);
  modport uart_tgt (input uart_cs, uart_wr, uart_sel, uart_wdata, output uart_rdata);

endinterface

// ==== design/io_map.sv ====
module io_map (
  input  logic             clk,
  input  logic             rst_n,
  input  soc_pkg::addr_t   addr_i,
  input  soc_pkg::strobe_t we_i,
  input  logic             re_i,
  input  soc_pkg::data_t   wdata_i,
  input  soc_pkg::gran_t   gran_i,
  output soc_pkg::data_t   rdata_o,
  input  soc_pkg::io_t     sw_i,
  output soc_pkg::io_t     led_o,
  periph_bus_if.ctrl       mem,
  periph_bus_if.ctrl       uart
);
  import soc_pkg::*;

  logic      mem_hit;
  logic      sw_hit;
  logic      uart_hit;
  logic      led_we;
  uart_sel_t sel_d;
  logic [4:0] lane_shift;
  strobe_t   lane_mask;
  logic      rd_mem_q;
  logic      rd_sw_q;
  logic      rd_uart_q;
  io_t       sw_q;
  io_t       led_q;

  ////////////////////
  // Address decode
  ////////////////////
  always_comb begin
    mem_hit  = addr_i < ADDR_DMEM_LIMIT;
    sw_hit   = 1'b0;
    uart_hit = 1'b0;
    led_we   = 1'b0;
    sel_d    = SEL_BUF;
    if (!mem_hit) begin
      case (addr_i)
        ADDR_LED:       led_we = |we_i;
        ADDR_SW:        sw_hit = 1'b1;
        ADDR_UART_BUF:  uart_hit = 1'b1;
        ADDR_UART_STAT: begin
          uart_hit = 1'b1;
          sel_d    = SEL_STAT;
        end
        ADDR_UART_DBL:  begin
          uart_hit = 1'b1;
          sel_d    = SEL_DBL;
        end
        ADDR_UART_DBH:  begin
          uart_hit = 1'b1;
          sel_d    = SEL_DBH;
        end
        // Unmapped, reads give zero
        default: ;
      endcase
    end
  end

  ////////////////////
  // Write alignment
  ////////////////////
  // Big-endian lanes, offset 0 is bits 31:24
  always_comb begin
    case (gran_i)
      GRAN_BYTE: begin
        lane_shift = {~addr_i[1:0], 3'b000};
        lane_mask  = 4'b1000 >> addr_i[1:0];
      end
      GRAN_HALF: begin
        // Odd half-word offsets fall onto the nearest even half
        lane_shift = addr_i[1] ? 5'd0 : 5'd16;
        lane_mask  = addr_i[1] ? 4'b0011 : 4'b1100;
      end
      default: begin
        lane_shift = 5'd0;
        lane_mask  = 4'b1111;
      end
    endcase
  end

  assign mem.mem_we    = mem_hit ? (we_i & lane_mask) : '0;
  assign mem.mem_addr  = addr_i[DMEM_WORDS_LOG2+1:2];
  assign mem.mem_wdata = wdata_i << lane_shift;
  assign mem.mem_gran  = gran_i;
  // Memory link carries no UART traffic
  assign mem.uart_cs    = 1'b0;
  assign mem.uart_wr    = 1'b0;
  assign mem.uart_sel   = SEL_BUF;
  assign mem.uart_wdata = '0;

  assign uart.uart_cs    = uart_hit & (re_i | (|we_i));
  assign uart.uart_wr    = |we_i;
  assign uart.uart_sel   = sel_d;
  assign uart.uart_wdata = wdata_i[7:0];
  // And the UART link no memory traffic
  assign uart.mem_we    = '0;
  assign uart.mem_addr  = '0;
  assign uart.mem_wdata = '0;
  assign uart.mem_gran  = '0;

  ////////////////////
  // LED and read source
  ////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      rd_mem_q  <= 1'b0;
      rd_sw_q   <= 1'b0;
      rd_uart_q <= 1'b0;
      led_q     <= '0;
    end else begin
      rd_mem_q  <= re_i & mem_hit;
      rd_sw_q   <= re_i & sw_hit;
      rd_uart_q <= re_i & uart_hit;
      if (led_we)
        led_q <= wdata_i[IO_WIDTH-1:0];
    end
  end

  // Switches as seen on the request cycle
  always_ff @(posedge clk) begin
    if (re_i && sw_hit)
      sw_q <= sw_i;
  end

  // Read data lands one cycle after the request
  always_comb begin
    rdata_o = '0;
    if (rd_mem_q)
      rdata_o = mem.mem_rdata;
    else if (rd_sw_q)
      rdata_o = data_t'(sw_q);
    else if (rd_uart_q)
      rdata_o = data_t'(uart.uart_rdata);
  end

  assign led_o = led_q;

endmodule

// ==== design/data_mem.sv ====
module data_mem (
  input  logic          clk,
  periph_bus_if.mem_tgt bus
);
  import soc_pkg::*;

  data_t   mem_q [DMEM_WORDS];
  logic    gran_ok;
  strobe_t lane_we;

  ////////////////////
  // Strobe check
  ////////////////////
  // Drop strobe patterns that cannot come from the given size
  always_comb begin
    case (bus.mem_gran)
      GRAN_BYTE: gran_ok = $onehot(bus.mem_we);
      GRAN_HALF: gran_ok = (bus.mem_we == 4'b1100) || (bus.mem_we == 4'b0011);
      default:   gran_ok = 1'b1;
    endcase
  end

  assign lane_we = gran_ok ? bus.mem_we : '0;

  ////////////////////
  // Storage
  ////////////////////
  // One strobe bit per byte lane, lane 3 is bits 31:24
  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (lane_we[i])
        mem_q[bus.mem_addr][i*8 +: 8] <= bus.mem_wdata[i*8 +: 8];
    end
  end

  // Registered read, old word on a same-cycle write
  always_ff @(posedge clk) begin
    bus.mem_rdata <= mem_q[bus.mem_addr];
  end

endmodule

// ==== design/uart_regs.sv ====
module uart_regs (
  input  logic           clk,
  input  logic           rst_n,
  periph_bus_if.uart_tgt bus,
  input  logic           rx_i,
  output logic           tx_o
);
  import soc_pkg::*;

  baud_div_t   baud_div_q;
  logic        wr_buf;
  logic        rd_buf;
  logic        wr_dbl;
  logic        wr_dbh;
  baud_div_t   tx_cnt_q;
  logic        tx_tick;
  uart_state_t tx_state_q;
  logic [2:0]  tx_bit_q;
  logic        tx_full_q;
  byte_t       tx_buf_q;
  byte_t       tx_shift_q;
  logic [1:0]  rx_sync_q;
  logic        rx_s;
  uart_state_t rx_state_q;
  baud_div_t   rx_cnt_q;
  logic        rx_sample;
  logic [2:0]  rx_bit_q;
  logic        rx_ready_q;
  logic        rx_done;
  byte_t       rx_shift_q;
  byte_t       rx_buf_q;

  assign wr_buf = bus.uart_cs & bus.uart_wr & (bus.uart_sel == SEL_BUF);
  assign rd_buf = bus.uart_cs & ~bus.uart_wr & (bus.uart_sel == SEL_BUF);
  assign wr_dbl = bus.uart_cs & bus.uart_wr & (bus.uart_sel == SEL_DBL);
  assign wr_dbh = bus.uart_cs & bus.uart_wr & (bus.uart_sel == SEL_DBH);

  // Divisor loaded a byte at a time
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      baud_div_q <= BAUD_DIV_RESET;
    else if (wr_dbl)
      baud_div_q[7:0] <= bus.uart_wdata;
    else if (wr_dbh)
      baud_div_q[15:8] <= bus.uart_wdata;
  end

  ////////////////////
  // Transmitter
  ////////////////////
  // Free-running bit clock, baud_div+1 cycles per tick
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      tx_cnt_q <= '0;
    else if (tx_tick)
      tx_cnt_q <= baud_div_q;
    else
      tx_cnt_q <= tx_cnt_q - 1'b1;
  end

  assign tx_tick = (tx_cnt_q == '0);

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      tx_state_q <= IDLE;
      tx_bit_q   <= '0;
      tx_full_q  <= 1'b0;
    end else begin
      if (tx_tick) begin
        case (tx_state_q)
          IDLE:
            if (tx_full_q)
              tx_state_q <= START;
          START: begin
            tx_state_q <= DATA;
            tx_bit_q   <= '0;
          end
          DATA: begin
            tx_bit_q <= tx_bit_q + 1'b1;
            // Buffer frees up as the stop bit starts
            if (tx_bit_q == 3'd7) begin
              tx_state_q <= STOP;
              tx_full_q  <= 1'b0;
            end
          end
          default: tx_state_q <= IDLE;
        endcase
      end
      // New byte wins over the clear
      if (wr_buf)
        tx_full_q <= 1'b1;
    end
  end

  // Buffer and shifter, LSB first on the line
  always_ff @(posedge clk) begin
    if (wr_buf)
      tx_buf_q <= bus.uart_wdata;
    if (tx_tick && tx_state_q == IDLE && tx_full_q)
      tx_shift_q <= tx_buf_q;
    else if (tx_tick && tx_state_q == DATA)
      tx_shift_q <= {1'b0, tx_shift_q[7:1]};
  end

  always_comb begin
    case (tx_state_q)
      START:   tx_o = 1'b0;
      DATA:    tx_o = tx_shift_q[0];
      default: tx_o = 1'b1;
    endcase
  end

  ////////////////////
  // Receiver
  ////////////////////
  // Two-flop sync, idles high
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      rx_sync_q <= 2'b11;
    else
      rx_sync_q <= {rx_sync_q[0], rx_i};
  end

  assign rx_s      = rx_sync_q[1];
  assign rx_sample = (rx_cnt_q == '0);
  assign rx_done   = (rx_state_q == STOP) & rx_sample & rx_s;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      rx_state_q <= IDLE;
      rx_cnt_q   <= '0;
      rx_bit_q   <= '0;
      rx_ready_q <= 1'b0;
    end else begin
      if (rd_buf)
        rx_ready_q <= 1'b0;
      if (rx_state_q != IDLE && !rx_sample)
        rx_cnt_q <= rx_cnt_q - 1'b1;
      case (rx_state_q)
        IDLE:
          // Half a bit to reach mid start bit
          if (!rx_s) begin
            rx_state_q <= START;
            rx_cnt_q   <= baud_div_q >> 1;
          end
        START:
          if (rx_sample) begin
            rx_cnt_q   <= baud_div_q;
            rx_bit_q   <= '0;
            // False start if the line went back high
            rx_state_q <= rx_s ? IDLE : DATA;
          end
        DATA:
          if (rx_sample) begin
            rx_cnt_q <= baud_div_q;
            rx_bit_q <= rx_bit_q + 1'b1;
            if (rx_bit_q == 3'd7)
              rx_state_q <= STOP;
          end
        default:
          if (rx_sample)
            rx_state_q <= IDLE;
      endcase
      // Frame completion wins over a read clear
      if (rx_done)
        rx_ready_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rx_state_q == DATA && rx_sample)
      rx_shift_q <= {rx_s, rx_shift_q[7:1]};
    if (rx_done)
      rx_buf_q <= rx_shift_q;
  end

  ////////////////////
  // Register read
  ////////////////////
  always_ff @(posedge clk) begin
    if (bus.uart_cs && !bus.uart_wr) begin
      case (bus.uart_sel)
        SEL_BUF:  bus.uart_rdata <= rx_buf_q;
        SEL_STAT: bus.uart_rdata <= {6'b0, tx_full_q, rx_ready_q};
        SEL_DBL:  bus.uart_rdata <= baud_div_q[7:0];
        default:  bus.uart_rdata <= baud_div_q[15:8];
      endcase
    end
  end

endmodule

// ==== design/periph_top.sv ====
module periph_top (
  input  logic             clk,
  input  logic             rst_n,
  // Master request, one cycle each
  input  soc_pkg::addr_t   addr_i,
  input  soc_pkg::strobe_t we_i,
  input  logic             re_i,
  input  soc_pkg::data_t   wdata_i,
  input  soc_pkg::gran_t   gran_i,
  output soc_pkg::data_t   rdata_o,
  // Board I/O
  input  soc_pkg::io_t     sw_i,
  output soc_pkg::io_t     led_o,
  input  logic             rx_i,
  output logic             tx_o
);

  // One link per target
  periph_bus_if mem_bus ();
  periph_bus_if uart_bus ();

  io_map io_map_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .addr_i  (addr_i),
    .we_i    (we_i),
    .re_i    (re_i),
    .wdata_i (wdata_i),
    .gran_i  (gran_i),
    .rdata_o (rdata_o),
    .sw_i    (sw_i),
    .led_o   (led_o),
    .mem     (mem_bus.ctrl),
    .uart    (uart_bus.ctrl)
  );

  data_mem data_mem_i (
    .clk (clk),
    .bus (mem_bus.mem_tgt)
  );

  uart_regs uart_regs_i (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (uart_bus.uart_tgt),
    .rx_i  (rx_i),
    .tx_o  (tx_o)
  );

endmodule

// ==== tests/bus_checker.sv ====
module bus_checker (
  input  logic             clk,
  input  logic             rst_n,
  input  soc_pkg::addr_t   addr_i,
  input  soc_pkg::strobe_t we_i,
  input  logic             re_i,
  input  soc_pkg::data_t   wdata_i,
  input  soc_pkg::gran_t   gran_i,
  input  soc_pkg::data_t   rdata_i,
  input  soc_pkg::io_t     sw_i,
  input  soc_pkg::io_t     led_i,
  input  logic             tx_i,
  output int               errors_o,
  output int               checks_o
);
  timeunit 1ns;
  timeprecision 100ps;
  import soc_pkg::*;

  data_t     ref_mem [int];
  byte_t     rx_expect [$];
  io_t       led_ref;
  baud_div_t div_ref;
  logic      uart_idle;
  logic      first_stat;
  logic      tx_cleared;
  logic      pend_rd;
  logic      pend_stat;
  data_t     pend_exp;
  addr_t     pend_addr;
  int        errors;
  int        checks;

  assign errors_o = errors;
  assign checks_o = checks;

  ////////////////////
  // Reference model
  ////////////////////
  // Byte offset 0 sits in bits 31:24 under strobe bit 3
  function automatic data_t merge_write(input data_t old_word, input addr_t addr,
                                        input strobe_t stb, input data_t wd,
                                        input gran_t gran);
    data_t res;
    int    off;
    res = old_word;
    off = int'(addr[1:0]);
    case (gran)
      GRAN_BYTE:
        if (stb[3-off])
          res[31-8*off -: 8] = wd[7:0];
      GRAN_HALF:
        // Half-word goes to the upper or lower pair of lanes
        if (!addr[1] && stb[3] && stb[2])
          res[31:16] = wd[15:0];
        else if (addr[1] && stb[1] && stb[0])
          res[15:0] = wd[15:0];
      default:
        for (int i = 0; i < 4; i++) begin
          if (stb[3-i])
            res[31-8*i -: 8] = wd[31-8*i -: 8];
        end
    endcase
    return res;
  endfunction

  task automatic apply_write();
    int idx;
    idx = int'(addr_i[DMEM_WORDS_LOG2+1:2]);
    if (addr_i < ADDR_DMEM_LIMIT) begin
      ref_mem[idx] = merge_write(ref_mem.exists(idx) ? ref_mem[idx] : '0, addr_i, we_i,
                                 wdata_i, gran_i);
    end else begin
      case (addr_i)
        ADDR_LED:      led_ref = wdata_i[IO_WIDTH-1:0];
        ADDR_UART_BUF: begin
          // Loopback returns the same byte
          rx_expect.push_back(wdata_i[7:0]);
          uart_idle  = 1'b0;
          first_stat = 1'b1;
          tx_cleared = 1'b0;
        end
        ADDR_UART_DBL: div_ref[7:0] = wdata_i[7:0];
        ADDR_UART_DBH: div_ref[15:8] = wdata_i[7:0];
        default: ;
      endcase
    end
  endtask

  task automatic expect_read();
    int idx;
    idx       = int'(addr_i[DMEM_WORDS_LOG2+1:2]);
    pend_rd   = 1'b1;
    pend_addr = addr_i;
    pend_exp  = '0;
    if (addr_i < ADDR_DMEM_LIMIT) begin
      if (ref_mem.exists(idx)) begin
        pend_exp = ref_mem[idx];
      end else begin
        pend_rd = 1'b0;
        errors++;
        $display("memory word at %h was read before the test wrote it", addr_i);
      end
    end else begin
      case (addr_i)
        ADDR_SW:       pend_exp = data_t'(sw_i);
        ADDR_UART_BUF: begin
          if (rx_expect.size() > 0) begin
            pend_exp  = data_t'(rx_expect.pop_front());
            uart_idle = 1'b1;
          end else begin
            pend_rd = 1'b0;
            errors++;
            $display("UART buffer was read with no byte in flight");
          end
        end
        // Idle status must read as zero, otherwise flag order applies
        ADDR_UART_STAT: pend_stat = !uart_idle;
        ADDR_UART_DBL:  pend_exp = data_t'(div_ref[7:0]);
        ADDR_UART_DBH:  pend_exp = data_t'(div_ref[15:8]);
        default: ;
      endcase
    end
  endtask

  ////////////////////
  // Comparison
  ////////////////////
  task automatic compare_read();
    checks++;
    if (rdata_i !== pend_exp) begin
      errors++;
      $display("error rdata_o addr %h expected %h actual %h", pend_addr, pend_exp, rdata_i);
    end
  endtask

  task automatic check_status();
    checks++;
    if (rdata_i[31:2] !== '0) begin
      errors++;
      $display("error rdata_o status bits 31:2 expected %h actual %h", 30'h0,
               rdata_i[31:2]);
    end
    if (first_stat) begin
      first_stat = 1'b0;
      if (rdata_i[1] !== 1'b1) begin
        errors++;
        $display("error rdata_o tx_full expected %h actual %h", 1'b1, rdata_i[1]);
      end
    end else begin
      if (rdata_i[0] && !tx_cleared) begin
        errors++;
        $display("rx_ready was set before tx_full was seen to clear");
      end
      if (!rdata_i[1])
        tx_cleared = 1'b1;
    end
  endtask

  task automatic report_counts();
    $display("bus_checker: %0d checks, %0d errors", checks, errors);
  endtask

  initial begin
    errors     = 0;
    checks     = 0;
    pend_rd    = 1'b0;
    pend_stat  = 1'b0;
    pend_exp   = '0;
    pend_addr  = '0;
    uart_idle  = 1'b1;
    first_stat = 1'b0;
    tx_cleared = 1'b0;
    led_ref    = '0;
    div_ref    = BAUD_DIV_RESET;
  end

  // Requests seen at the edge that ends them
  always @(posedge clk) begin
    pend_rd   = 1'b0;
    pend_stat = 1'b0;
    if (!rst_n) begin
      led_ref   = '0;
      div_ref   = BAUD_DIV_RESET;
      uart_idle = 1'b1;
      rx_expect.delete();
    end else if (|we_i) begin
      apply_write();
    end else if (re_i) begin
      expect_read();
    end
  end

  // Outputs are stable mid cycle
  always @(negedge clk) begin
    if (rst_n) begin
      if (pend_rd && pend_stat)
        check_status();
      else if (pend_rd)
        compare_read();
      checks++;
      if (led_i !== led_ref) begin
        errors++;
        $display("error led_o expected %h actual %h", led_ref, led_i);
      end
      if (uart_idle && tx_i !== 1'b1) begin
        errors++;
        $display("error tx_o expected %h actual %h", 1'b1, tx_i);
      end
    end
  end

endmodule

// ==== tests/tb_top.sv ====
module tb_top;
  timeunit 1ns;
  timeprecision 100ps;
  import soc_pkg::*;

  localparam int NUM_WORDS      = 16;
  localparam int TEST_DIV       = 20;
  localparam int FRAME_CYCLES   = 10 * (TEST_DIV + 1);
  // Word phase, sub-word phase, I/O phase, UART phase
  localparam int NUM_OPS        = 2 * NUM_WORDS + 16 + 9 + 17;
  localparam int TIMEOUT_CYCLES = NUM_OPS * (20 * FRAME_CYCLES + 10);

  logic    clk;
  logic    rst_n;
  addr_t   addr;
  strobe_t we;
  logic    re;
  data_t   wdata;
  gran_t   gran;
  data_t   rdata;
  io_t     sw;
  io_t     led;
  logic    serial;
  int      errors;
  int      checks;
  int      seed;
  addr_t   word_addr [NUM_WORDS];

  // TX looped back into RX
  periph_top periph_top_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .addr_i  (addr),
    .we_i    (we),
    .re_i    (re),
    .wdata_i (wdata),
    .gran_i  (gran),
    .rdata_o (rdata),
    .sw_i    (sw),
    .led_o   (led),
    .rx_i    (serial),
    .tx_o    (serial)
  );

  bus_checker checker_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .addr_i   (addr),
    .we_i     (we),
    .re_i     (re),
    .wdata_i  (wdata),
    .gran_i   (gran),
    .rdata_i  (rdata),
    .sw_i     (sw),
    .led_i    (led),
    .tx_i     (serial),
    .errors_o (errors),
    .checks_o (checks)
  );

  always #10 clk = ~clk;

  ////////////////////
  // Bus tasks
  ////////////////////
  // One request cycle, then the bus goes idle
  task automatic bus_write(input addr_t a, input data_t d, input gran_t g);
    @(posedge clk);
    #2;
    addr  = a;
    we    = 4'hF;
    re    = 1'b0;
    wdata = d;
    gran  = g;
    @(posedge clk);
    #2;
    we = '0;
  endtask

  task automatic bus_read(input addr_t a, output data_t d);
    @(posedge clk);
    #2;
    addr = a;
    we   = '0;
    re   = 1'b1;
    gran = '0;
    @(posedge clk);
    #2;
    re = 1'b0;
    d  = rdata;
  endtask

  // Watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    checker_i.report_counts();
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    data_t rd;
    data_t wd;
    clk   = 1'b0;
    rst_n = 1'b0;
    addr  = '0;
    we    = '0;
    re    = 1'b0;
    wdata = '0;
    gran  = '0;
    sw    = '0;
    seed  = 61784;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Random words across the memory
    for (int i = 0; i < NUM_WORDS; i++) begin
      word_addr[i] = addr_t'(($unsigned($random(seed)) % DMEM_WORDS) * 4);
      wd = $random(seed);
      bus_write(word_addr[i], wd, 2'd0);
    end
    for (int i = 0; i < NUM_WORDS; i++)
      bus_read(word_addr[i], rd);

    // Byte and half-word writes at every offset
    for (int off = 0; off < 4; off++) begin
      wd = $random(seed);
      bus_write(word_addr[0] + addr_t'(off), wd, GRAN_BYTE);
      bus_read(word_addr[0], rd);
    end
    for (int off = 0; off < 4; off++) begin
      wd = $random(seed);
      bus_write(word_addr[1] + addr_t'(off), wd, GRAN_HALF);
      bus_read(word_addr[1], rd);
    end

    // LEDs, switches and unmapped space
    wd = $random(seed);
    bus_write(ADDR_LED, wd, 2'd0);
    wd = $random(seed);
    bus_write(ADDR_LED, wd, 2'd0);
    sw = io_t'($random(seed));
    bus_read(ADDR_SW, rd);
    sw = io_t'($random(seed));
    bus_read(ADDR_SW, rd);
    bus_read(16'h8000, rd);
    bus_read(16'hC002, rd);
    bus_write(16'h8000 + word_addr[2], wd, 2'd0);
    bus_write(16'hC003, wd, 2'd0);
    bus_read(word_addr[2], rd);

    // UART status and divisor straight after reset
    bus_read(ADDR_UART_STAT, rd);
    bus_read(ADDR_UART_DBL, rd);
    bus_read(ADDR_UART_DBH, rd);
    // High divisor byte on its own first
    bus_write(ADDR_UART_DBH, data_t'(TEST_DIV / 256 + 1), 2'd0);
    bus_read(ADDR_UART_DBH, rd);
    bus_write(ADDR_UART_DBL, data_t'(TEST_DIV % 256), 2'd0);
    bus_write(ADDR_UART_DBH, data_t'(TEST_DIV / 256), 2'd0);
    bus_read(ADDR_UART_DBL, rd);
    bus_read(ADDR_UART_DBH, rd);

    // Two loopback bytes
    for (int i = 0; i < 2; i++) begin
      wd = $random(seed);
      bus_write(ADDR_UART_BUF, wd, 2'd0);
      do begin
        bus_read(ADDR_UART_STAT, rd);
      end while (!rd[0]);
      bus_read(ADDR_UART_BUF, rd);
      bus_read(ADDR_UART_STAT, rd);
    end

    repeat (2) @(posedge clk);
    checker_i.report_counts();
    if (errors == 0 && checks > 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== verilog.f ====
design/soc_pkg.sv
design/periph_bus_if.sv
design/io_map.sv
design/data_mem.sv
design/uart_regs.sv
design/periph_top.sv
tests/bus_checker.sv
tests/tb_top.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = tb_top
FILELIST  = verilog.f
BUILD     = obj_dir
LOG       = sim.log
PASS_MSG  = ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
